//--- src/mio_rx_pkg.sv
// Shared widths, field positions and types for the mesh IO receive path; FIFO_DEPTH must be a power of two
package mio_rx_pkg;

   //######################################################################
   // Widths
   //######################################################################
   localparam int PW         = 104;             // Mesh packet width
   localparam int AW         = 32;              // Address and data word
   localparam int BEAT_W     = 64;              // IO beat data
   localparam int BV_W       = BEAT_W / 8;      // One valid bit per byte
   localparam int FIFO_DEPTH = 16;              // CDC FIFO entries
   localparam int FIFO_AW    = $clog2(FIFO_DEPTH); // RAM index width
   localparam int NUM_SLOTS  = 3;               // Beats per packet-mode packet

   //######################################################################
   // Types
   //######################################################################
   typedef logic [BEAT_W-1:0] beat_t;           // Beat payload
   typedef logic [BV_W-1:0]   bvalid_t;         // Byte-valid field
   typedef logic [AW-1:0]     addr_t;           // Address or data word
   typedef logic [4:0]        ctrl_t;           // Control mode
   typedef logic [1:0]        dmode_t;          // Data mode
   typedef logic [PW-1:0]     packet_t;         // Mesh packet

   //######################################################################
   // Packet field positions, bit 0 upward
   //######################################################################
   localparam int WRITE_BIT = 0;                // Write flag

   localparam int DMODE_LSB = 1;                // Data mode
   localparam int DMODE_MSB = 2;

   localparam int CTRL_LSB  = 3;                // Control mode
   localparam int CTRL_MSB  = 7;

   localparam int DST_LSB   = 8;                // Destination address
   localparam int DST_MSB   = 39;

   localparam int DATA_LSB  = 40;               // Data word
   localparam int DATA_MSB  = 71;

   localparam int SRC_LSB   = 72;               // Source address
   localparam int SRC_MSB   = 103;

   // Address mode always writes full 64-bit words
   localparam dmode_t AMODE_DATAMODE = 2'd3;

endpackage

//--- src/mrx_beat_if.sv
// Beat handshake inside the clk domain only; the sink may raise pop only while avail is high
interface mrx_beat_if;

   logic                avail;   // FIFO not empty
   mio_rx_pkg::beat_t   data;    // Head beat payload
   mio_rx_pkg::bvalid_t bvalid;  // Head beat byte valids
   logic                pop;     // Consume head beat

   // FIFO read side
   modport src (
      output avail,
      output data,
      output bvalid,
      input  pop
   );

   // Assembler side
   modport snk (
      input  avail,
      input  data,
      input  bvalid,
      output pop
   );

endinterface

//--- src/mrx_cdc_fifo.sv
// Writer must hold access_in low while wait_out is high; nreset is applied to both clock domains at once
module mrx_cdc_fifo (
   input  logic                clk_in,     // Write clock, rx_clk
   input  logic                clk,        // Read clock, core
   input  logic                nreset,
   input  logic                access_in,  // Beat write strobe
   input  mio_rx_pkg::beat_t   data_in,
   input  mio_rx_pkg::bvalid_t bvalid_in,
   output logic                wait_out,   // Full in write domain
   mrx_beat_if.src             rd          // Read side towards assembler
);

   // Storage, no reset
   mio_rx_pkg::beat_t   mem_data   [mio_rx_pkg::FIFO_DEPTH];
   mio_rx_pkg::bvalid_t mem_bvalid [mio_rx_pkg::FIFO_DEPTH];

   // Write domain pointers
   logic [mio_rx_pkg::FIFO_AW:0] wr_bin;       // Extra wrap bit on top
   logic [mio_rx_pkg::FIFO_AW:0] wr_gray;
   logic [mio_rx_pkg::FIFO_AW:0] wr_bin_next;
   logic [mio_rx_pkg::FIFO_AW:0] wr_gray_next;
   logic [mio_rx_pkg::FIFO_AW:0] rd_gray_s1;   // Read pointer seen by writer
   logic [mio_rx_pkg::FIFO_AW:0] rd_gray_s2;
   logic                         full;
   logic                         wr_en;

   // Read domain pointers
   logic [mio_rx_pkg::FIFO_AW:0] rd_bin;
   logic [mio_rx_pkg::FIFO_AW:0] rd_gray;
   logic [mio_rx_pkg::FIFO_AW:0] rd_bin_next;
   logic [mio_rx_pkg::FIFO_AW:0] rd_gray_next;
   logic [mio_rx_pkg::FIFO_AW:0] wr_gray_s1;   // Write pointer seen by reader
   logic [mio_rx_pkg::FIFO_AW:0] wr_gray_s2;
   logic                         empty;
   logic                         rd_en;

   //######################################################################
   // Write side, clk_in domain
   //######################################################################
   assign wr_bin_next  = wr_bin + 1'b1;
   assign wr_gray_next = (wr_bin_next >> 1) ^ wr_bin_next;

   // Full when top two gray bits differ and the rest match
   assign full  = (wr_gray == {~rd_gray_s2[mio_rx_pkg::FIFO_AW -: 2],
                               rd_gray_s2[mio_rx_pkg::FIFO_AW-2:0]});
   assign wr_en = access_in & ~full;    // Drop guard if sender misbehaves

   assign wait_out = full;

   always_ff @(posedge clk_in or negedge nreset) begin
      if (!nreset) begin
         wr_bin  <= '0;
         wr_gray <= '0;
      end else if (wr_en) begin
         wr_bin  <= wr_bin_next;
         wr_gray <= wr_gray_next;       // Only one bit flips per write
      end
   end

   // RAM write port
   always_ff @(posedge clk_in) begin
      if (wr_en) begin
         mem_data[wr_bin[mio_rx_pkg::FIFO_AW-1:0]]   <= data_in;
         mem_bvalid[wr_bin[mio_rx_pkg::FIFO_AW-1:0]] <= bvalid_in;
      end
   end

   // Read pointer into write domain
   always_ff @(posedge clk_in or negedge nreset) begin
      if (!nreset) begin
         rd_gray_s1 <= '0;
         rd_gray_s2 <= '0;
      end else begin
         rd_gray_s1 <= rd_gray;
         rd_gray_s2 <= rd_gray_s1;
      end
   end

   //######################################################################
   // Read side, clk domain
   //######################################################################
   assign rd_bin_next  = rd_bin + 1'b1;
   assign rd_gray_next = (rd_bin_next >> 1) ^ rd_bin_next;

   assign empty = (rd_gray == wr_gray_s2);   // Pointers equal incl. wrap bit
   assign rd_en = rd.pop & ~empty;

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         rd_bin  <= '0;
         rd_gray <= '0;
      end else if (rd_en) begin
         rd_bin  <= rd_bin_next;
         rd_gray <= rd_gray_next;
      end
   end

   // Write pointer into read domain, sets avail latency
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         wr_gray_s1 <= '0;
         wr_gray_s2 <= '0;
      end else begin
         wr_gray_s1 <= wr_gray;
         wr_gray_s2 <= wr_gray_s1;
      end
   end

   // Head of queue, asynchronous RAM read
   assign rd.avail  = ~empty;
   assign rd.data   = mem_data[rd_bin[mio_rx_pkg::FIFO_AW-1:0]];
   assign rd.bvalid = mem_bvalid[rd_bin[mio_rx_pkg::FIFO_AW-1:0]];

endmodule

//--- src/mrx_assembler.sv
// amode, ctrlmode and dstaddr are static while beats flow; a short packet carries stale upper slot bits
module mrx_assembler (
   input  logic                clk,
   input  logic                nreset,
   input  logic                amode,      // 1 address mode, 0 packet mode
   input  mio_rx_pkg::ctrl_t   ctrlmode,   // Address mode control field
   input  mio_rx_pkg::addr_t   dstaddr,    // Address mode destination
   mrx_beat_if.snk             rd,         // Beats from CDC FIFO
   input  logic                pkt_ready,  // Output stage can take one
   output logic                pkt_valid,  // One-cycle packet strobe
   output mio_rx_pkg::packet_t pkt
);

   logic                pop;
   logic                beat_end;          // Partial byte valids end packet
   mio_rx_pkg::packet_t amode_pkt;
   mio_rx_pkg::packet_t pmode_pkt;

   // Packet mode slots
   mio_rx_pkg::beat_t                                       slot_q [mio_rx_pkg::NUM_SLOTS];
   logic [mio_rx_pkg::NUM_SLOTS-1:0]                        slot_ptr;      // One-hot
   logic [mio_rx_pkg::NUM_SLOTS-1:0]                        slot_ptr_next;
   logic [mio_rx_pkg::NUM_SLOTS*mio_rx_pkg::BEAT_W-1:0]     slot_cat;      // Slots with bypass

   //######################################################################
   // Handshake
   //######################################################################

   // Pop only when a packet could be accepted this edge
   assign pop    = rd.avail & pkt_ready;
   assign rd.pop = pop;

   assign beat_end = ~&rd.bvalid;

   // Every beat in address mode, ending beat in packet mode
   assign pkt_valid = pop & (amode | beat_end);

   //######################################################################
   // Address mode, one write packet per beat
   //######################################################################
   always_comb begin
      amode_pkt = '0;
      amode_pkt[mio_rx_pkg::WRITE_BIT] = 1'b1;
      amode_pkt[mio_rx_pkg::DMODE_MSB:mio_rx_pkg::DMODE_LSB] = mio_rx_pkg::AMODE_DATAMODE;
      amode_pkt[mio_rx_pkg::CTRL_MSB:mio_rx_pkg::CTRL_LSB]   = ctrlmode;
      amode_pkt[mio_rx_pkg::DST_MSB:mio_rx_pkg::DST_LSB]     = dstaddr;
      // Low half is data, high half is source
      amode_pkt[mio_rx_pkg::DATA_MSB:mio_rx_pkg::DATA_LSB] =
         rd.data[mio_rx_pkg::AW-1:0];
      amode_pkt[mio_rx_pkg::SRC_MSB:mio_rx_pkg::SRC_LSB] =
         rd.data[mio_rx_pkg::BEAT_W-1:mio_rx_pkg::AW];
   end

   //######################################################################
   // Packet mode, slot assembly
   //######################################################################

   // Back to slot 0 after an ending beat, else rotate up (wraps on overflow)
   assign slot_ptr_next = beat_end ?
                          {{(mio_rx_pkg::NUM_SLOTS-1){1'b0}}, 1'b1} :
                          {slot_ptr[mio_rx_pkg::NUM_SLOTS-2:0],
                           slot_ptr[mio_rx_pkg::NUM_SLOTS-1]};

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         slot_ptr <= {{(mio_rx_pkg::NUM_SLOTS-1){1'b0}}, 1'b1};   // Start in slot 0
      end else if (pop && !amode) begin
         slot_ptr <= slot_ptr_next;
      end
   end

   // Payload slots, no reset
   always_ff @(posedge clk) begin
      if (pop && !amode) begin
         for (int i = 0; i < mio_rx_pkg::NUM_SLOTS; i++) begin
            if (slot_ptr[i]) begin
               slot_q[i] <= rd.data;
            end
         end
      end
   end

   // Current beat bypassed into its slot so the packet is ready on the pop edge
   for (genvar g = 0; g < mio_rx_pkg::NUM_SLOTS; g++) begin : g_slot
      assign slot_cat[g*mio_rx_pkg::BEAT_W +: mio_rx_pkg::BEAT_W] =
         slot_ptr[g] ? rd.data : slot_q[g];
   end

   assign pmode_pkt = slot_cat[mio_rx_pkg::PW-1:0];   // Beat 0 in low bits

   //######################################################################
   // Packet select
   //######################################################################
   assign pkt = amode ? amode_pkt : pmode_pkt;

endmodule

//--- src/mrx_out_stage.sv
// Single-entry output register; a packet held under wait_in keeps access_out and packet_out unchanged
module mrx_out_stage (
   input  logic                clk,
   input  logic                nreset,
   input  logic                pkt_valid,   // From assembler
   input  mio_rx_pkg::packet_t pkt,
   output logic                pkt_ready,   // Room for next packet
   input  logic                wait_in,     // Pushback from mesh
   output logic                access_out,  // Packet held
   output mio_rx_pkg::packet_t packet_out
);

   logic xfer;      // Packet moves in this edge
   logic consume;   // Held packet leaves this edge

   //######################################################################
   // Handshake
   //######################################################################

   // Empty, or current packet leaves on this edge
   assign pkt_ready = ~access_out | ~wait_in;

   assign xfer    = pkt_valid & pkt_ready;
   assign consume = access_out & ~wait_in;

   //######################################################################
   // Valid flag
   //######################################################################
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         access_out <= 1'b0;
      end else if (xfer) begin
         access_out <= 1'b1;           // New packet, maybe back to back
      end else if (consume) begin
         access_out <= 1'b0;           // Drained, nothing behind it
      end
   end

   //######################################################################
   // Packet register
   //######################################################################

   // Loads only on transfer, so held value stays put under wait
   always_ff @(posedge clk) begin
      if (xfer) begin
         packet_out <= pkt;
      end
   end

endmodule

//--- src/mrx_top.sv
// Receive top for the mesh IO link; amode, ctrlmode and dstaddr are static and both clocks share nreset
module mrx_top (
   input  logic                clk,         // Core clock
   input  logic                nreset,      // Async, active low
   input  logic                rx_clk,      // IO receive clock
   // Static configuration
   input  logic                amode,       // Address mode select
   input  mio_rx_pkg::ctrl_t   ctrlmode,
   input  mio_rx_pkg::addr_t   dstaddr,
   // IO side, rx_clk domain
   input  logic                io_access,
   input  mio_rx_pkg::bvalid_t io_valid,
   input  mio_rx_pkg::beat_t   io_packet,
   output logic                rx_wait,
   // Mesh side, clk domain
   input  logic                wait_in,
   output logic                access_out,
   output mio_rx_pkg::packet_t packet_out
);

   logic                pkt_valid;
   logic                pkt_ready;
   mio_rx_pkg::packet_t pkt;

   mrx_beat_if beat_if ();   // FIFO head to assembler

   //######################################################################
   // Clock crossing
   //######################################################################
   mrx_cdc_fifo u_fifo (
      .clk_in    (rx_clk),
      .clk       (clk),
      .nreset    (nreset),
      .access_in (io_access),
      .data_in   (io_packet),
      .bvalid_in (io_valid),
      .wait_out  (rx_wait),
      .rd        (beat_if.src)
   );

   // Beats to packets
   mrx_assembler u_asm (
      .clk       (clk),
      .nreset    (nreset),
      .amode     (amode),
      .ctrlmode  (ctrlmode),
      .dstaddr   (dstaddr),
      .rd        (beat_if.snk),
      .pkt_ready (pkt_ready),
      .pkt_valid (pkt_valid),
      .pkt       (pkt)
   );

   mrx_out_stage u_out (
      .clk        (clk),
      .nreset     (nreset),
      .pkt_valid  (pkt_valid),
      .pkt        (pkt),
      .pkt_ready  (pkt_ready),
      .wait_in    (wait_in),
      .access_out (access_out),
      .packet_out (packet_out)
   );

endmodule

//--- test/mrx_checker.sv
// Bound into mrx_top; the assertions act only when the simulator is built with assertions enabled
module mrx_checker (
   input logic                clk,
   input logic                rx_clk,
   input logic                nreset,
   input logic                io_access,
   input logic                rx_wait,
   input logic                wait_in,
   input logic                access_out,
   input mio_rx_pkg::packet_t packet_out
);

   // Nothing presented while in reset
   a_reset_quiet: assert property (@(posedge clk) !nreset |-> !access_out)
      else $error("access_out high during reset");

   // Held packet keeps valid and value under wait_in
   a_hold_stable: assert property (@(posedge clk) disable iff (!nreset)
      $past(access_out && wait_in) |-> (access_out && packet_out == $past(packet_out)))
      else $error("packet_out changed while held by wait_in");

   // IO sender honors pushback
   a_no_write_on_wait: assert property (@(posedge rx_clk) disable iff (!nreset)
      !(io_access && rx_wait))
      else $error("io_access high while rx_wait is high");

endmodule

bind mrx_top mrx_checker u_checker (
   .clk        (clk),
   .rx_clk     (rx_clk),
   .nreset     (nreset),
   .io_access  (io_access),
   .rx_wait    (rx_wait),
   .wait_in    (wait_in),
   .access_out (access_out),
   .packet_out (packet_out)
);

//--- test/mrx_tb.sv
// Testbench for mrx_top; amode, ctrlmode and dstaddr change only while the path is drained
module mrx_tb;

   localparam logic [31:0] SEED  = 32'h6363_5c67;
   localparam int          LIMIT = 4000;        // Cycles allowed per wait loop

   logic                clk;
   logic                rx_clk;
   logic                nreset;
   logic                amode;
   mio_rx_pkg::ctrl_t   ctrlmode;
   mio_rx_pkg::addr_t   dstaddr;
   logic                io_access;
   mio_rx_pkg::bvalid_t io_valid;
   mio_rx_pkg::beat_t   io_packet;
   logic                rx_wait;
   logic                wait_in;
   logic                access_out;
   mio_rx_pkg::packet_t packet_out;

   mio_rx_pkg::packet_t exp_q [$];              // Expected packets, oldest first
   mio_rx_pkg::beat_t   slot_model [mio_rx_pkg::NUM_SLOTS];
   int                  slot_idx;               // Model of the slot pointer
   logic [31:0]         rng;                    // Stimulus LCG state
   logic [31:0]         wait_rng;               // wait_in LCG state
   logic [1:0]          wait_mode;              // 0 low, 1 random, 2 held high
   logic                held_prev;              // Packet held on last edge
   mio_rx_pkg::packet_t held_pkt;
   int                  mismatch_count;
   int                  fail_count;
   logic                timed_out;

   mrx_top UUT (.*);

   always #5 clk = ~clk;
   always #7 rx_clk = ~rx_clk;

   //######################################################################
   // Stimulus helpers and reference model
   //######################################################################
   function automatic logic [31:0] lcg_step(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // Address mode uses b0 only; packet mode takes the low PW bits of {b1, b0}
   function automatic mio_rx_pkg::packet_t ref_packet(input logic am,
         input mio_rx_pkg::ctrl_t cm, input mio_rx_pkg::addr_t da,
         input mio_rx_pkg::beat_t b0, input mio_rx_pkg::beat_t b1);
      logic [2*mio_rx_pkg::BEAT_W-1:0] cat;
      mio_rx_pkg::packet_t             p;
      p   = '0;
      cat = {b1, b0};
      if (am) begin
         p[mio_rx_pkg::WRITE_BIT] = 1'b1;
         p[mio_rx_pkg::DMODE_MSB:mio_rx_pkg::DMODE_LSB] = 2'd3;   // Full word
         p[mio_rx_pkg::CTRL_MSB:mio_rx_pkg::CTRL_LSB]   = cm;
         p[mio_rx_pkg::DST_MSB:mio_rx_pkg::DST_LSB]     = da;
         p[mio_rx_pkg::DATA_MSB:mio_rx_pkg::DATA_LSB]   = b0[31:0];
         p[mio_rx_pkg::SRC_MSB:mio_rx_pkg::SRC_LSB]     = b0[63:32];
      end else begin
         p = cat[mio_rx_pkg::PW-1:0];
      end
      return p;
   endfunction

   // One beat on the IO side, after rx_wait allows it
   task automatic send_beat(input mio_rx_pkg::beat_t data, input mio_rx_pkg::bvalid_t bv);
      int n;
      n = 0;
      if (timed_out) return;
      @(negedge rx_clk);
      while (rx_wait && !timed_out) begin
         io_access = 1'b0;                      // Pause while FIFO is full
         n++;
         if (n > LIMIT) begin
            fail_count++;
            timed_out = 1'b1;
            $display("ERROR: rx_wait stayed high, a beat could not be written");
         end else begin
            @(negedge rx_clk);
         end
      end
      if (timed_out) return;
      io_access = 1'b1;
      io_packet = data;
      io_valid  = bv;
      if (amode) begin
         exp_q.push_back(ref_packet(1'b1, ctrlmode, dstaddr, data, '0));
      end else begin
         slot_model[slot_idx] = data;
         if (bv != '1) begin                    // Ending beat
            exp_q.push_back(ref_packet(1'b0, ctrlmode, dstaddr, slot_model[0], slot_model[1]));
            slot_idx = 0;
         end else begin
            slot_idx = (slot_idx + 1) % mio_rx_pkg::NUM_SLOTS;
         end
      end
   endtask

   task automatic send_random(input logic full);
      mio_rx_pkg::beat_t b;
      rng = lcg_step(rng);
      b[63:32] = rng;
      rng = lcg_step(rng);
      b[31:0] = rng;
      rng = lcg_step(rng);
      send_beat(b, full ? 8'hFF : (rng[15:8] & 8'h7F));   // Partial never all ones
   endtask

   // Full beats followed by one partial beat
   task automatic send_packet(input int beats);
      for (int i = 0; i < beats; i++) begin
         send_random(i != beats - 1);
      end
   endtask

   task automatic idle_io;
      @(negedge rx_clk);
      io_access = 1'b0;
   endtask

   task automatic set_wait(input logic [1:0] m);
      @(posedge clk);                           // Away from the wait_in driver edge
      wait_mode = m;
   endtask

   task automatic drain;
      int n;
      n = 0;
      idle_io();
      while ((exp_q.size() != 0 || access_out) && !timed_out) begin
         n++;
         if (n > LIMIT) begin
            fail_count++;
            timed_out = 1'b1;
            $display("ERROR: %0d expected packets never came out", exp_q.size());
         end else begin
            @(negedge clk);
         end
      end
   endtask

   task automatic wait_full;
      int n;
      n = 0;
      while (!rx_wait && !timed_out) begin
         n++;
         if (n > LIMIT) begin
            fail_count++;
            timed_out = 1'b1;
            $display("ERROR: rx_wait never rose while the output was held");
         end else begin
            @(negedge rx_clk);
         end
      end
   endtask

   //######################################################################
   // wait_in pattern and output comparison
   //######################################################################
   always @(negedge clk) begin
      wait_rng = lcg_step(wait_rng);
      case (wait_mode)
         2'd1:    wait_in = wait_rng[16];       // About half the cycles
         2'd2:    wait_in = 1'b1;
         default: wait_in = 1'b0;
      endcase
   end

   always @(posedge clk) begin : compare_outputs
      mio_rx_pkg::packet_t want;
      if (nreset && access_out && !wait_in) begin   // Consumed on this edge
         if (exp_q.size() == 0) begin
            fail_count++;
            $display("ERROR: packet_out consumed with no packet expected, %h", packet_out);
         end else begin
            want = exp_q.pop_front();
            if (packet_out !== want) begin
               mismatch_count++;
               $display("MISMATCH packet_out expected %h actual %h", want, packet_out);
            end
         end
      end
      if (held_prev && packet_out !== held_pkt) begin
         mismatch_count++;
         $display("MISMATCH packet_out held expected %h actual %h", held_pkt, packet_out);
      end
      held_prev = nreset && access_out && wait_in;
      held_pkt  = packet_out;
   end

   //######################################################################
   // Test sequence
   //######################################################################
   initial begin
      clk            = 1'b0;
      rx_clk         = 1'b0;
      nreset         = 1'b0;
      amode          = 1'b1;
      ctrlmode       = '0;
      dstaddr        = '0;
      io_access      = 1'b0;
      io_valid       = '0;
      io_packet      = '0;
      wait_in        = 1'b0;
      wait_mode      = 2'd0;
      rng            = SEED;
      wait_rng       = lcg_step(SEED);
      slot_idx       = 0;
      held_prev      = 1'b0;
      held_pkt       = '0;
      mismatch_count = 0;
      fail_count     = 0;
      timed_out      = 1'b0;
      for (int i = 0; i < mio_rx_pkg::NUM_SLOTS; i++) begin
         slot_model[i] = '0;
      end
      repeat (8) @(posedge clk);
      @(negedge clk);
      nreset = 1'b1;
      if (access_out !== 1'b0) begin            // Reset state
         mismatch_count++;
         $display("MISMATCH access_out expected %h actual %h", 1'b0, access_out);
      end
      if (rx_wait !== 1'b0) begin
         mismatch_count++;
         $display("MISMATCH rx_wait expected %h actual %h", 1'b0, rx_wait);
      end
      rng      = lcg_step(rng);                 // Address mode, no wait
      ctrlmode = rng[4:0];
      rng      = lcg_step(rng);
      dstaddr  = rng;
      repeat (20) send_random(1'b1);
      drain();
      amode = 1'b0;                             // Packet mode, two beats each
      repeat (10) send_packet(2);
      drain();
      for (int i = 0; i < 16; i++) begin        // Mixed lengths
         rng = lcg_step(rng);
         send_packet(rng[20] ? 2 : 1);
      end
      drain();
      set_wait(2'd1);                           // Random back-pressure, long burst
      for (int i = 0; i < 80; i++) begin
         rng = lcg_step(rng);
         send_packet(rng[20] ? 2 : 1);
      end
      set_wait(2'd0);
      drain();
      amode = 1'b1;                             // Fill the FIFO behind a held packet
      set_wait(2'd2);
      repeat (mio_rx_pkg::FIFO_DEPTH + 1) send_random(1'b1);
      idle_io();
      wait_full();
      set_wait(2'd0);
      repeat (8) send_random(1'b1);
      drain();
      repeat (50) @(negedge clk);               // Catch any extra packet
      $display("Errors: %0d mismatches, %0d other failures", mismatch_count, fail_count);
      if (mismatch_count == 0 && fail_count == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

//--- filelist.f
src/mio_rx_pkg.sv
src/mrx_beat_if.sv
src/mrx_cdc_fifo.sv
src/mrx_assembler.sv
src/mrx_out_stage.sv
src/mrx_top.sv
test/mrx_checker.sv
test/mrx_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile with Verilator, run, and pass only if the pass line is printed
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module mrx_tb -Mdir obj_dir -f filelist.f
out=$(./obj_dir/Vmrx_tb) || true
echo "$out"
if echo "$out" | grep -q "SIMULATION PASSED"; then
   exit 0
fi
exit 1
